// ==== Bender.yml ====
package:
  name: fetch_frontend

export_include_dirs:
  - common

sources:
  - files:
      - common/fetch_pkg.sv
      - common/wb_pkg.sv
      - icache/cache_way.sv
      - icache/icache.sv
      - logic/fetch_unit.sv
      - logic/wb_rom.sv
      - logic/fetch_top.sv
  - target: test
    files:
      - verification/fetch_tb.sv

// ==== build.f ====
+incdir+common
common/fetch_pkg.sv
common/wb_pkg.sv
icache/cache_way.sv
icache/icache.sv
logic/fetch_unit.sv
logic/wb_rom.sv
logic/fetch_top.sv
verification/fetch_tb.sv

// ==== common/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// core side sizes, addresses count 32-bit instruction words.
`define FETCH_AW 16
`define FETCH_IW 32

// wishbone data path.
`define WB_DW 16

// instruction cache geometry.
`define ICACHE_WAYS 4
`define ICACHE_SETS 32
`define ICACHE_IDX_W 5
`define ICACHE_OFF_W 2
`define ICACHE_TAG_W 9
`define ICACHE_LINE_W 128
`define ICACHE_BEATS 8

// boot rom wait cycles before each acknowledge.
`define ROM_WAIT 1

`endif

// ==== common/fetch_pkg.sv ====
`include "fetch_config.svh"

package fetch_pkg;

    // address presented to the cache with a submit.
    typedef struct packed {
        logic [`FETCH_AW-1:0] addr;
    } fetch_req_t;

    // one delivered instruction and its pc.
    typedef struct packed {
        logic [`FETCH_AW-1:0] pc;
        logic [`FETCH_IW-1:0] instr;
    } fetch_out_t;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT
    } fetch_state_e;

    // valid sits in the low bit.
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]  tag;
        logic [`ICACHE_LINE_W-1:0] line;
        logic                      valid;
    } cache_entry_t;

endpackage

// ==== common/wb_pkg.sv ====
`include "fetch_config.svh"

package wb_pkg;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`WB_DW-1:0]    adr;
    } wb_m2s_t;

    typedef struct packed {
        logic                 ack;
        logic [`WB_DW-1:0]    dat;
    } wb_s2m_t;

    // flush_wait is a burst that finishes but is never written back.
    typedef enum logic [1:0] {
        LOOKUP,
        REFILL,
        FLUSH_WAIT
    } refill_state_e;

endpackage

// ==== icache/cache_way.sv ====
`include "fetch_config.svh"

module cache_way (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_inval,
    input  logic [`ICACHE_IDX_W-1:0]    i_addr,
    input  logic                        i_we,
    input  fetch_pkg::cache_entry_t     i_entry,
    output fetch_pkg::cache_entry_t     o_entry
);

    logic [`ICACHE_TAG_W+`ICACHE_LINE_W-1:0] data_mem [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]                 valid_q;

    // tag and line storage, read returns the old contents on a write.
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            data_mem[i_addr] <= {i_entry.tag, i_entry.line};
        end
        o_entry <= {data_mem[i_addr], valid_q[i_addr]};
    end

    // all valid bits drop together.
    always_ff @(posedge i_clk) begin
        if (i_rst || i_inval) begin
            valid_q <= '0;
        end else if (i_we) begin
            valid_q[i_addr] <= i_entry.valid;
        end
    end

endmodule

// ==== icache/icache.sv ====
`include "fetch_config.svh"

module icache (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_req,
    input  logic                    i_submit,
    input  fetch_pkg::fetch_req_t   i_addr,
    input  logic                    i_flush,
    output logic                    o_ack,
    output logic [`FETCH_IW-1:0]    o_instr,
    output wb_pkg::wb_m2s_t         o_wb,
    input  wb_pkg::wb_s2m_t         i_wb
);

    import fetch_pkg::*;
    import wb_pkg::*;

    localparam int WAY_W = $clog2(`ICACHE_WAYS);
    localparam int BEAT_W = $clog2(`ICACHE_BEATS);
    localparam int TAG_LSB = `ICACHE_IDX_W + `ICACHE_OFF_W;

    refill_state_e              state_q;
    fetch_req_t                 lookup_q;
    fetch_req_t                 refill_q;
    fetch_req_t                 pending_q;
    fetch_req_t                 read_addr;
    logic                       lookup_valid_q;
    logic                       pending_valid_q;
    logic                       flush_q;
    logic [BEAT_W-1:0]          beat_q;
    logic [WAY_W-1:0]           victim_q;
    logic [`ICACHE_LINE_W-1:0]  line_q;

    cache_entry_t               way_out [`ICACHE_WAYS];
    cache_entry_t               fill_entry;
    logic [`ICACHE_WAYS-1:0]    hit_vec;
    logic [`ICACHE_WAYS-1:0]    way_we;
    logic [`ICACHE_IDX_W-1:0]   way_idx;
    logic [`ICACHE_LINE_W-1:0]  hit_line;
    logic [`ICACHE_LINE_W-1:0]  fill_line;
    logic [`ICACHE_LINE_W-1:0]  sel_line;
    logic [`ICACHE_OFF_W-1:0]   sel_off;

    logic busy;
    logic bus_ack;
    logic burst_end;
    logic lookup_hit;
    logic lookup_miss;
    logic accept_ok;
    logic new_lookup;

    assign busy = (state_q != LOOKUP);
    assign bus_ack = busy && i_wb.ack;
    assign burst_end = bus_ack && (beat_q == BEAT_W'(`ICACHE_BEATS - 1));

    // a lookup right after a flush still sees the old valid bits.
    assign lookup_hit = lookup_valid_q && (|hit_vec) && !flush_q;
    assign lookup_miss = lookup_valid_q && !((|hit_vec) && !flush_q);

    assign accept_ok = i_req && !busy && !lookup_miss;
    assign new_lookup = accept_ok && (pending_valid_q || i_submit);
    assign read_addr = pending_valid_q ? pending_q : i_addr;

    // last beat goes straight into the line, not through line_q.
    assign fill_line = {i_wb.dat, line_q[`ICACHE_LINE_W-`WB_DW-1:0]};
    assign fill_entry = '{
        tag:   refill_q.addr[`FETCH_AW-1:TAG_LSB],
        line:  fill_line,
        valid: 1'b1
    };

    assign way_idx = (|way_we) ? refill_q.addr[TAG_LSB-1:`ICACHE_OFF_W]
                               : read_addr.addr[TAG_LSB-1:`ICACHE_OFF_W];

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        assign way_we[w] = burst_end && (state_q == REFILL) && !i_flush
                           && (victim_q == WAY_W'(w));
        assign hit_vec[w] = way_out[w].valid
                            && (way_out[w].tag == lookup_q.addr[`FETCH_AW-1:TAG_LSB]);

        cache_way u_way (
            .i_clk   (i_clk),
            .i_rst   (i_rst),
            .i_inval (i_flush),
            .i_addr  (way_idx),
            .i_we    (way_we[w]),
            .i_entry (fill_entry),
            .o_entry (way_out[w])
        );
    end

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hit_vec[w]) begin
                hit_line = hit_line | way_out[w].line;
            end
        end
    end

    assign sel_line = burst_end ? fill_line : hit_line;
    assign sel_off = burst_end ? refill_q.addr[`ICACHE_OFF_W-1:0]
                               : lookup_q.addr[`ICACHE_OFF_W-1:0];
    assign o_instr = sel_line[sel_off*`FETCH_IW +: `FETCH_IW];
    assign o_ack = lookup_hit || burst_end;

    // halfword address of the current beat.
    assign o_wb = '{
        cyc: busy,
        stb: busy,
        we:  1'b0,
        adr: {refill_q.addr[`FETCH_AW-2:`ICACHE_OFF_W], beat_q}
    };

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            lookup_valid_q <= 1'b0;
            pending_valid_q <= 1'b0;
            flush_q <= 1'b0;
        end else begin
            lookup_valid_q <= new_lookup;
            flush_q <= i_flush;
            if (i_submit && !accept_ok) begin
                pending_valid_q <= 1'b1;
            end else if (accept_ok) begin
                pending_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (new_lookup) begin
            lookup_q <= read_addr;
        end
        if (i_submit && !accept_ok) begin
            pending_q <= i_addr;
        end
        if (!busy && lookup_miss) begin
            refill_q <= lookup_q;
        end
        if (bus_ack) begin
            line_q[beat_q*`WB_DW +: `WB_DW] <= i_wb.dat;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q <= LOOKUP;
            beat_q <= '0;
            victim_q <= '0;
        end else begin
            // beat counter wraps to zero on the last ack.
            if (bus_ack) begin
                beat_q <= beat_q + 1'b1;
            end
            if (|way_we) begin
                victim_q <= victim_q + 1'b1;
            end
            case (state_q)
                LOOKUP: begin
                    if (lookup_miss) begin
                        state_q <= i_flush ? FLUSH_WAIT : REFILL;
                    end
                end
                REFILL: begin
                    if (burst_end) begin
                        state_q <= LOOKUP;
                    end else if (i_flush) begin
                        state_q <= FLUSH_WAIT;
                    end
                end
                FLUSH_WAIT: begin
                    if (burst_end) begin
                        state_q <= LOOKUP;
                    end
                end
                default: state_q <= LOOKUP;
            endcase
        end
    end

    a_one_way_hit: assert property (@(posedge i_clk) disable iff (i_rst)
        lookup_valid_q |-> $onehot0(hit_vec))
        else $error("icache: more than one way hit");

    a_burst_held: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_wb.cyc && !burst_end) |=> (o_wb.cyc && o_wb.stb))
        else $error("icache: bus cycle dropped before the last beat");

endmodule

// ==== logic/fetch_top.sv ====
`include "fetch_config.svh"

module fetch_top (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_redirect,
    input  logic [`FETCH_AW-1:0]    i_redirect_pc,
    input  logic                    i_flush,
    output logic                    o_fetch_valid,
    output fetch_pkg::fetch_out_t   o_fetch,
    output logic                    o_bus_cyc
);

    import fetch_pkg::*;
    import wb_pkg::*;

    fetch_req_t             fetch_addr;
    logic                   fetch_req;
    logic                   fetch_submit;
    logic                   cache_ack;
    logic [`FETCH_IW-1:0]   cache_instr;
    wb_m2s_t                wb_m2s;
    wb_s2m_t                wb_s2m;

    fetch_unit u_fetch (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .i_flush       (i_flush),
        .o_req         (fetch_req),
        .o_submit      (fetch_submit),
        .o_addr        (fetch_addr),
        .i_ack         (cache_ack),
        .i_instr       (cache_instr),
        .o_fetch_valid (o_fetch_valid),
        .o_fetch       (o_fetch)
    );

    icache u_icache (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_req    (fetch_req),
        .i_submit (fetch_submit),
        .i_addr   (fetch_addr),
        .i_flush  (i_flush),
        .o_ack    (cache_ack),
        .o_instr  (cache_instr),
        .o_wb     (wb_m2s),
        .i_wb     (wb_s2m)
    );

    wb_rom u_rom (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_wb  (wb_m2s),
        .o_wb  (wb_s2m)
    );

    // refill activity, one rise per burst.
    assign o_bus_cyc = wb_m2s.cyc;

endmodule

// ==== logic/fetch_unit.sv ====
`include "fetch_config.svh"

module fetch_unit (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_redirect,
    input  logic [`FETCH_AW-1:0]    i_redirect_pc,
    input  logic                    i_flush,
    output logic                    o_req,
    output logic                    o_submit,
    output fetch_pkg::fetch_req_t   o_addr,
    input  logic                    i_ack,
    input  logic [`FETCH_IW-1:0]    i_instr,
    output logic                    o_fetch_valid,
    output fetch_pkg::fetch_out_t   o_fetch
);

    import fetch_pkg::*;

    fetch_state_e           state_q;
    logic [`FETCH_AW-1:0]   pc_q;
    logic [`FETCH_AW-1:0]   pc_inc;
    logic                   discard_q;
    logic                   kill;
    logic                   deliver;

    assign kill = i_redirect || i_flush;
    assign pc_inc = pc_q + 1'b1;
    assign deliver = (state_q == WAIT) && i_ack && !kill;

    // next pc goes out in the same cycle as the ack.
    assign o_req = (state_q != IDLE);
    assign o_submit = !kill && (((state_q == ISSUE) && !discard_q) || deliver);
    assign o_addr = '{addr: (state_q == WAIT) ? pc_inc : pc_q};

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q <= IDLE;
            pc_q <= '0;
            discard_q <= 1'b0;
            o_fetch_valid <= 1'b0;
        end else begin
            o_fetch_valid <= deliver;
            if (i_redirect) begin
                pc_q <= i_redirect_pc;
            end else if (deliver) begin
                pc_q <= pc_inc;
            end
            case (state_q)
                IDLE: state_q <= ISSUE;
                ISSUE: begin
                    // the stale ack has to come back before a new submit.
                    if (i_ack) begin
                        discard_q <= 1'b0;
                    end
                    if (!kill && !discard_q) begin
                        state_q <= WAIT;
                    end
                end
                WAIT: begin
                    if (kill) begin
                        discard_q <= !i_ack;
                        state_q <= ISSUE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (deliver) begin
            o_fetch <= '{pc: pc_q, instr: i_instr};
        end
    end

    a_no_submit_owed: assert property (@(posedge i_clk) disable iff (i_rst)
        o_submit |-> !discard_q)
        else $error("fetch_unit: submit while a stale ack is owed");

endmodule

// ==== logic/wb_rom.sv ====
`include "fetch_config.svh"

module wb_rom (
    input  logic              i_clk,
    input  logic              i_rst,
    input  wb_pkg::wb_m2s_t   i_wb,
    output wb_pkg::wb_s2m_t   o_wb
);

    localparam int CNT_W = $clog2(`ROM_WAIT + 2);
    localparam logic [`WB_DW-1:0] ROM_KEY = 16'h3C5A;

    logic [CNT_W-1:0]   wait_q;
    logic               ack_q;
    logic [`WB_DW-1:0]  dat_q;
    logic               access;
    logic               ready;

    assign access = i_wb.cyc && i_wb.stb && !ack_q;
    assign ready = access && (wait_q == CNT_W'(`ROM_WAIT));

    // count restarts after every ack, so each beat pays the full wait.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wait_q <= '0;
            ack_q <= 1'b0;
        end else if (ready) begin
            wait_q <= '0;
            ack_q <= 1'b1;
        end else if (access) begin
            wait_q <= wait_q + 1'b1;
            ack_q <= 1'b0;
        end else begin
            wait_q <= '0;
            ack_q <= 1'b0;
        end
    end

    // fixed image, each halfword is its own address scrambled.
    always_ff @(posedge i_clk) begin
        if (ready && !i_wb.we) begin
            dat_q <= i_wb.adr ^ ROM_KEY;
        end
    end

    assign o_wb = '{ack: ack_q, dat: dat_q};

endmodule

// ==== verification/fetch_golden.txt ====
# code(R redirect, F flush+redirect) start_pc(hex) count first_instr(hex) refill_bursts
# cold line, then the same line again as hits
R 0010 4 3C7B3C7A 1
R 0010 4 3C7B3C7A 0
# five tags on set 8, round-robin eviction
R 00A0 2 3D1B3D1A 1
R 0120 2 3E1B3E1A 1
R 01A0 2 3F1B3F1A 1
R 0220 2 381B381A 1
R 02A0 2 391B391A 1
R 00A0 2 3D1B3D1A 1
R 02A0 2 391B391A 0
# run across a line boundary
R 0102 6 3E5F3E5E 2
# flush during a refill, hit again, flush while idle
F 0010 4 3C7B3C7A 1
R 0010 4 3C7B3C7A 0
F 0010 4 3C7B3C7A 1

// ==== verification/fetch_tb.sv ====
`include "fetch_config.svh"

module fetch_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import fetch_pkg::*;

    localparam int STALL_LIMIT = 200;
    localparam int RANDOM_RUNS = 4;

    logic                   i_clk;
    logic                   i_rst;
    logic                   i_redirect;
    logic [`FETCH_AW-1:0]   i_redirect_pc;
    logic                   i_flush;
    logic                   o_fetch_valid;
    fetch_out_t             o_fetch;
    logic                   o_bus_cyc;

    integer seed;

    fetch_top dut_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .i_flush       (i_flush),
        .o_fetch_valid (o_fetch_valid),
        .o_fetch       (o_fetch),
        .o_bus_cyc     (o_bus_cyc)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // high halfword comes from 2a+1 and the low halfword from 2a.
    function automatic logic [`FETCH_IW-1:0] rom_instr(input logic [`FETCH_AW-1:0] pc);
        logic [15:0] h;
        h = {pc[14:0], 1'b0};
        return {(h + 16'd1) ^ 16'h3C5A, h ^ 16'h3C5A};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_fetch(input fetch_out_t exp, input fetch_out_t act, input string name);
        if (exp !== act) begin
            $display("FAIL time=%0t %s expected pc=%h instr=%h actual pc=%h instr=%h",
                     $time, name, exp.pc, exp.instr, act.pc, act.instr);
            abort_run("fetched instruction mismatch");
        end
    endtask

    task automatic check_count(input int exp, input int act, input string name);
        if (exp != act) begin
            $display("FAIL time=%0t %s expected %0d actual %0d", $time, name, exp, act);
            abort_run("refill count mismatch");
        end
    endtask

    // samples on the falling edge and counts bus cycle rises while n instructions arrive.
    task automatic collect_stream(input logic [`FETCH_AW-1:0] start, input int n,
                                  input logic [`FETCH_IW-1:0] first_exp, input logic cyc_init,
                                  output int rises);
        int         got;
        int         stall;
        logic       prev_cyc;
        fetch_out_t exp;
        got = 0;
        stall = 0;
        rises = 0;
        prev_cyc = cyc_init;
        while (got < n) begin
            @(negedge i_clk);
            if (o_bus_cyc && !prev_cyc) begin
                rises++;
            end
            prev_cyc = o_bus_cyc;
            if (o_fetch_valid) begin
                exp.pc = start + `FETCH_AW'(got);
                exp.instr = rom_instr(exp.pc);
                if (got == 0) begin
                    check_fetch('{pc: start, instr: first_exp}, o_fetch, "o_fetch golden");
                end
                check_fetch(exp, o_fetch, "o_fetch");
                got++;
                stall = 0;
            end else begin
                stall++;
                if (stall > STALL_LIMIT) begin
                    abort_run("timeout waiting for o_fetch_valid");
                end
            end
        end
    endtask

    // redirect with an optional flush and then run n instructions.
    task automatic run_command(input logic [7:0] code, input logic [`FETCH_AW-1:0] start,
                               input int n, input logic [`FETCH_IW-1:0] first_exp,
                               output int rises);
        logic cyc_at_redirect;
        @(posedge i_clk);
        i_redirect <= 1'b1;
        i_redirect_pc <= start;
        i_flush <= (code == "F");
        // a rise in the redirect cycle belongs to the old path.
        @(negedge i_clk);
        cyc_at_redirect = o_bus_cyc;
        @(posedge i_clk);
        i_redirect <= 1'b0;
        i_flush <= 1'b0;
        collect_stream(start, n, first_exp, cyc_at_redirect, rises);
    endtask

    initial begin
        integer                 fd;
        string                  line;
        int                     fields;
        int                     rises;
        int                     line_no;
        logic [7:0]             code;
        logic [`FETCH_AW-1:0]   start;
        int                     n;
        logic [`FETCH_IW-1:0]   first_exp;
        int                     bursts_exp;
        logic [`FETCH_AW-1:0]   target;

        seed = 32'h150e;
        i_rst = 1'b1;
        i_redirect = 1'b0;
        i_redirect_pc = '0;
        i_flush = 1'b0;
        repeat (5) @(posedge i_clk);
        i_rst <= 1'b0;

        // cold start at pc 0 fills one line.
        collect_stream('0, 4, rom_instr('0), 1'b0, rises);
        check_count(1, rises, "o_bus_cyc rises after reset");

        fd = $fopen("verification/fetch_golden.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verification/fetch_golden.txt");
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%c %h %d %h %d", code, start, n, first_exp, bursts_exp);
            if (fields != 5) begin
                abort_run($sformatf("golden line %0d is malformed", line_no));
            end
            run_command(code, start, n, first_exp, rises);
            check_count(bursts_exp, rises, $sformatf("o_bus_cyc rises line %0d", line_no));
        end
        $fclose(fd);

        // random targets check the data only.
        for (int i = 0; i < RANDOM_RUNS; i++) begin
            target = `FETCH_AW'($random(seed));
            run_command("R", target, 3, rom_instr(target), rises);
        end

        $display("Regression passed");
        $finish;
    end

endmodule
